// File: hw/audio_pkg.sv
package audio_pkg;

  localparam int NUM_TAPS    = 8;
  localparam int SAMPLE_BITS = 16;
  localparam int ACC_BITS    = 40;
  localparam int COEF_FRAC   = 15;  // Q1.15 fraction bits
  localparam int BCLK_DIV    = 2;   // clk_i cycles per bclk half period
  localparam int FRAME_BITS  = 32;  // Bit clocks per stereo frame

  typedef logic [9:0]  wb_adr_t;
  typedef logic [31:0] wb_dat_t;
  typedef logic [3:0]  wb_sel_t;

  typedef logic signed [SAMPLE_BITS-1:0] sample_t;
  typedef logic signed [15:0]            coef_t;
  typedef logic signed [ACC_BITS-1:0]    acc_t;
  typedef logic [$clog2(NUM_TAPS)-1:0]   tap_idx_t;
  typedef logic [$clog2(FRAME_BITS)-1:0] bit_idx_t;

  localparam sample_t SAMPLE_MAX  = 16'sh7FFF;
  localparam sample_t SAMPLE_MIN  = 16'sh8000;
  localparam coef_t   COEF0_RESET = 16'sh7FFF;  // Unity gain on tap 0

  // Address windows selected by adr[9:8]
  localparam logic [1:0] WIN_FIR   = 2'b00;
  localparam logic [1:0] WIN_CODEC = 2'b01;

  localparam wb_adr_t ADDR_FIR_CTRL     = 10'h000;
  localparam wb_adr_t ADDR_FIR_COEF0    = 10'h004;  // Tap k at +4k
  localparam wb_adr_t ADDR_CODEC_CTRL   = 10'h100;
  localparam wb_adr_t ADDR_CODEC_FRAMES = 10'h104;

  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_t;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
    wb_sel_t sel;
  } wb_req_t;

  typedef struct packed {
    logic    ack;
    logic    err;
    wb_dat_t dat;
  } wb_rsp_t;

  typedef enum logic {
    IDLE,
    RUN
  } codec_state_e;

endpackage

// File: hw/audio_wb_decoder.sv
`timescale 1ns/1ns

module audio_wb_decoder (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  audio_pkg::wb_req_t wb_req_i,
  output audio_pkg::wb_rsp_t wb_rsp_o,

  output audio_pkg::wb_req_t fir_req_o,
  input  audio_pkg::wb_rsp_t fir_rsp_i,
  output audio_pkg::wb_req_t codec_req_o,
  input  audio_pkg::wb_rsp_t codec_rsp_i
);

  logic       err_q;
  logic       req_valid;
  logic [1:0] win;
  logic       mapped;

  always_comb begin
    win       = wb_req_i.adr[9:8];
    req_valid = wb_req_i.cyc && wb_req_i.stb;
    mapped    = (win == audio_pkg::WIN_FIR) || (win == audio_pkg::WIN_CODEC);

    fir_req_o       = wb_req_i;
    fir_req_o.stb   = wb_req_i.stb && (win == audio_pkg::WIN_FIR);  // Only the hit slave
    codec_req_o     = wb_req_i;
    codec_req_o.stb = wb_req_i.stb && (win == audio_pkg::WIN_CODEC);
  end

  // Unmapped space answers with a single err pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_valid && !mapped && !err_q;
    end
  end

  always_comb begin
    wb_rsp_o.ack = fir_rsp_i.ack | codec_rsp_i.ack;
    wb_rsp_o.err = fir_rsp_i.err | codec_rsp_i.err | err_q;
    wb_rsp_o.dat = (fir_rsp_i.ack ? fir_rsp_i.dat : '0) |
                   (codec_rsp_i.ack ? codec_rsp_i.dat : '0);
  end

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wb_rsp_o.ack && wb_rsp_o.err));

  // Slaves and decoder together never answer back to back
  a_single_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_rsp_o.ack || wb_rsp_o.err) |=> !(wb_rsp_o.ack || wb_rsp_o.err));

endmodule

// File: hw/audio_fir_regs.sv
`timescale 1ns/1ns

module audio_fir_regs (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,

  input  audio_pkg::wb_req_t                        wb_req_i,
  output audio_pkg::wb_rsp_t                        wb_rsp_o,

  output audio_pkg::coef_t [audio_pkg::NUM_TAPS-1:0] coef_o,
  output logic                                      bypass_o
);

  audio_pkg::coef_t [audio_pkg::NUM_TAPS-1:0] coef_q;
  logic                                      bypass_q;
  logic                                      ack_q;
  audio_pkg::wb_dat_t                        rdata_q;

  logic                access;  // Pending and not yet acked
  logic                ctrl_hit;
  logic                coef_hit;
  audio_pkg::wb_adr_t  coef_off;
  audio_pkg::tap_idx_t coef_idx;
  audio_pkg::coef_t    coef_rd;

  always_comb begin
    access   = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    ctrl_hit = (wb_req_i.adr == audio_pkg::ADDR_FIR_CTRL);
    coef_off = wb_req_i.adr - audio_pkg::ADDR_FIR_COEF0;
    coef_hit = (wb_req_i.adr >= audio_pkg::ADDR_FIR_COEF0) &&
               (coef_off[1:0] == 2'b00) &&
               (int'(coef_off[9:2]) < audio_pkg::NUM_TAPS);
    coef_idx = coef_off[$bits(audio_pkg::tap_idx_t)+1:2];  // Word index
    coef_rd  = coef_q[coef_idx];
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      bypass_q  <= 1'b0;
      coef_q    <= '0;
      coef_q[0] <= audio_pkg::COEF0_RESET;
    end else begin
      ack_q <= access;
      if (access && wb_req_i.we) begin
        if (ctrl_hit && wb_req_i.sel[0]) begin
          bypass_q <= wb_req_i.dat[0];
        end
        if (coef_hit) begin
          if (wb_req_i.sel[0]) begin
            coef_q[coef_idx][7:0] <= wb_req_i.dat[7:0];
          end
          if (wb_req_i.sel[1]) begin
            coef_q[coef_idx][15:8] <= wb_req_i.dat[15:8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !wb_req_i.we) begin
      if (ctrl_hit) begin
        rdata_q <= {31'b0, bypass_q};
      end else if (coef_hit) begin
        rdata_q <= {{16{coef_rd[15]}}, coef_rd};  // Sign extended
      end else begin
        rdata_q <= '0;  // Hole in the map
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = rdata_q;

  assign coef_o   = coef_q;
  assign bypass_o = bypass_q;

endmodule

// File: hw/audio_fir_core.sv
`timescale 1ns/1ns

module audio_fir_core (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,

  input  audio_pkg::sample_t                        sample_i,
  input  logic                                      sample_valid_i,
  input  audio_pkg::coef_t [audio_pkg::NUM_TAPS-1:0] coef_i,
  input  logic                                      bypass_i,

  output audio_pkg::sample_t                        y_o,
  output logic                                      y_valid_o
);

  // dline_q[k] holds the sample delayed by k
  audio_pkg::sample_t [audio_pkg::NUM_TAPS-1:0] dline_q;
  audio_pkg::tap_idx_t                          tap_q;
  logic                                         busy_q;   // MAC phase
  logic                                         done_q;   // Sum ready for output stage
  audio_pkg::acc_t                              acc_q;

  logic signed [2*audio_pkg::SAMPLE_BITS-1:0] prod;
  audio_pkg::acc_t                            shifted;
  audio_pkg::sample_t                         sat;

  always_comb begin
    prod    = $signed(coef_i[tap_q]) * $signed(dline_q[tap_q]);
    shifted = acc_q >>> audio_pkg::COEF_FRAC;
    if (shifted > audio_pkg::acc_t'(audio_pkg::SAMPLE_MAX)) begin
      sat = audio_pkg::SAMPLE_MAX;
    end else if (shifted < audio_pkg::acc_t'(audio_pkg::SAMPLE_MIN)) begin
      sat = audio_pkg::SAMPLE_MIN;
    end else begin
      sat = shifted[audio_pkg::SAMPLE_BITS-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dline_q   <= '0;
      tap_q     <= '0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      y_valid_o <= 1'b0;
    end else begin
      y_valid_o <= 1'b0;
      done_q    <= 1'b0;
      if (sample_valid_i) begin
        dline_q <= {dline_q[audio_pkg::NUM_TAPS-2:0], sample_i};
        tap_q   <= '0;
        busy_q  <= 1'b1;
      end else if (busy_q) begin
        tap_q <= tap_q + 1'b1;
        if (tap_q == audio_pkg::tap_idx_t'(audio_pkg::NUM_TAPS - 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end else if (done_q) begin
        y_valid_o <= 1'b1;
      end
    end
  end

  // Accumulator and result
  always_ff @(posedge clk_i) begin
    if (sample_valid_i) begin
      acc_q <= '0;
    end else if (busy_q) begin
      acc_q <= acc_q + audio_pkg::acc_t'(prod);
    end
    if (done_q) begin
      y_o <= bypass_i ? dline_q[0] : sat;  // Bypass keeps the same latency
    end
  end

  a_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sample_valid_i |-> !(busy_q || done_q));

endmodule

// File: hw/audio_codec_if.sv
`timescale 1ns/1ns

module audio_codec_if (
  input  logic                clk_i,
  input  logic                rst_n_i,

  input  audio_pkg::wb_req_t  wb_req_i,
  output audio_pkg::wb_rsp_t  wb_rsp_o,

  input  logic                adc_sdata_i,
  output logic                bclk_o,
  output logic                lrclk_o,
  output logic                dac_sdata_o,

  output audio_pkg::stereo_t  sample_o,
  output logic                sample_valid_o,
  input  audio_pkg::sample_t  tx_left_i,
  input  logic                tx_left_valid_i,
  input  audio_pkg::sample_t  tx_right_i,
  input  logic                tx_right_valid_i
);

  audio_pkg::codec_state_e state_q;
  logic                    en_q;
  audio_pkg::wb_dat_t      frames_q;
  logic                    ack_q;
  audio_pkg::wb_dat_t      rdata_q;

  logic [$clog2(audio_pkg::BCLK_DIV)-1:0] div_q;
  audio_pkg::bit_idx_t                    bit_q;  // Bit slot within frame
  logic                                   bclk_q;
  logic                                   dac_q;
  logic [audio_pkg::FRAME_BITS-1:0]       rx_q;
  logic [audio_pkg::FRAME_BITS-1:0]       tx_q;
  audio_pkg::stereo_t                     hold_q;  // Latest filtered pair

  logic access;
  logic half_end;
  logic bclk_rise;
  logic bclk_fall;
  logic last_bit;
  logic frame_end;
  logic tx_load;

  always_comb begin
    access    = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    half_end  = (state_q == audio_pkg::RUN) && (int'(div_q) == audio_pkg::BCLK_DIV - 1);
    bclk_rise = half_end && !bclk_q;
    bclk_fall = half_end && bclk_q;
    last_bit  = (bit_q == audio_pkg::bit_idx_t'(audio_pkg::FRAME_BITS - 1));
    frame_end = bclk_fall && last_bit;
    tx_load   = en_q && ((state_q == audio_pkg::IDLE) || frame_end);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q    <= 1'b0;
      en_q     <= 1'b0;
      frames_q <= '0;
    end else begin
      ack_q <= access;
      if (access && wb_req_i.we && wb_req_i.adr == audio_pkg::ADDR_CODEC_CTRL &&
          wb_req_i.sel[0]) begin
        en_q <= wb_req_i.dat[0];
      end
      if (access && wb_req_i.we && wb_req_i.adr == audio_pkg::ADDR_CODEC_FRAMES) begin
        frames_q <= '0;  // Any write clears
      end else if (frame_end) begin
        frames_q <= frames_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !wb_req_i.we) begin
      case (wb_req_i.adr)
        audio_pkg::ADDR_CODEC_CTRL:   rdata_q <= {31'b0, en_q};
        audio_pkg::ADDR_CODEC_FRAMES: rdata_q <= frames_q;
        default:                      rdata_q <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q        <= audio_pkg::IDLE;
      div_q          <= '0;
      bit_q          <= '0;
      bclk_q         <= 1'b0;
      dac_q          <= 1'b0;
      sample_valid_o <= 1'b0;
      hold_q         <= '0;
    end else begin
      sample_valid_o <= bclk_rise && last_bit;  // Right LSB just sampled
      if (tx_left_valid_i) begin
        hold_q.left <= tx_left_i;
      end
      if (tx_right_valid_i) begin
        hold_q.right <= tx_right_i;
      end
      case (state_q)
        audio_pkg::IDLE: begin
          div_q  <= '0;
          bit_q  <= '0;
          bclk_q <= 1'b0;
          dac_q  <= 1'b0;
          if (en_q) begin
            state_q <= audio_pkg::RUN;
            dac_q   <= hold_q.left[audio_pkg::SAMPLE_BITS-1];
          end
        end
        audio_pkg::RUN: begin
          div_q <= half_end ? '0 : div_q + 1'b1;
          if (half_end) begin
            bclk_q <= !bclk_q;
          end
          if (bclk_fall) begin
            bit_q <= bit_q + 1'b1;  // Wraps at frame end, lrclk follows MSB
            if (!frame_end) begin
              dac_q <= tx_q[audio_pkg::FRAME_BITS-2];
            end else if (en_q) begin
              dac_q <= hold_q.left[audio_pkg::SAMPLE_BITS-1];
            end else begin
              state_q <= audio_pkg::IDLE;
              dac_q   <= 1'b0;
            end
          end
        end
        default: state_q <= audio_pkg::IDLE;
      endcase
    end
  end

  // Shift registers
  always_ff @(posedge clk_i) begin
    if (bclk_rise) begin
      rx_q <= {rx_q[audio_pkg::FRAME_BITS-2:0], adc_sdata_i};
      if (last_bit) begin
        sample_o <= {rx_q[audio_pkg::FRAME_BITS-2:0], adc_sdata_i};
      end
    end
    if (tx_load) begin
      tx_q <= hold_q;
    end else if (bclk_fall) begin
      tx_q <= tx_q << 1;
    end
  end

  assign bclk_o      = bclk_q;
  assign lrclk_o     = bit_q[$bits(audio_pkg::bit_idx_t)-1];  // High for right slots
  assign dac_sdata_o = dac_q;

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = 1'b0;
  assign wb_rsp_o.dat = rdata_q;

  // Word clock moves only with a falling bit clock
  a_lrclk_on_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $changed(lrclk_o) |-> $fell(bclk_o));

endmodule

// File: hw/audio_filter_top.sv
`timescale 1ns/1ns

module audio_filter_top (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  audio_pkg::wb_req_t wb_req_i,
  output audio_pkg::wb_rsp_t wb_rsp_o,

  input  logic               adc_sdata_i,
  output logic               bclk_o,
  output logic               lrclk_o,
  output logic               dac_sdata_o
);

  audio_pkg::wb_req_t fir_req;
  audio_pkg::wb_rsp_t fir_rsp;
  audio_pkg::wb_req_t codec_req;
  audio_pkg::wb_rsp_t codec_rsp;

  audio_pkg::coef_t [audio_pkg::NUM_TAPS-1:0] coef;  // Shared by both channels
  logic                                      bypass;

  audio_pkg::stereo_t sample;
  logic               sample_valid;
  audio_pkg::sample_t y_left;
  logic               y_left_valid;
  audio_pkg::sample_t y_right;
  logic               y_right_valid;

  audio_wb_decoder wb_decoder_i (
    .clk_i,
    .rst_n_i,
    .wb_req_i,
    .wb_rsp_o,
    .fir_req_o  (fir_req),
    .fir_rsp_i  (fir_rsp),
    .codec_req_o(codec_req),
    .codec_rsp_i(codec_rsp)
  );

  audio_fir_regs fir_regs_i (
    .clk_i,
    .rst_n_i,
    .wb_req_i(fir_req),
    .wb_rsp_o(fir_rsp),
    .coef_o  (coef),
    .bypass_o(bypass)
  );

  audio_fir_core fir_left_i (
    .clk_i,
    .rst_n_i,
    .sample_i      (sample.left),
    .sample_valid_i(sample_valid),
    .coef_i        (coef),
    .bypass_i      (bypass),
    .y_o           (y_left),
    .y_valid_o     (y_left_valid)
  );

  audio_fir_core fir_right_i (
    .clk_i,
    .rst_n_i,
    .sample_i      (sample.right),
    .sample_valid_i(sample_valid),
    .coef_i        (coef),
    .bypass_i      (bypass),
    .y_o           (y_right),
    .y_valid_o     (y_right_valid)
  );

  audio_codec_if codec_i (
    .clk_i,
    .rst_n_i,
    .wb_req_i        (codec_req),
    .wb_rsp_o        (codec_rsp),
    .adc_sdata_i,
    .bclk_o,
    .lrclk_o,
    .dac_sdata_o,
    .sample_o        (sample),
    .sample_valid_o  (sample_valid),
    .tx_left_i       (y_left),
    .tx_left_valid_i (y_left_valid),
    .tx_right_i      (y_right),
    .tx_right_valid_i(y_right_valid)
  );

endmodule

// File: tb/audio_filter_checker.sv
`timescale 1ns/1ns

module audio_filter_checker (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  audio_pkg::wb_req_t wb_req_i,
  input  audio_pkg::wb_rsp_t wb_rsp_i,
  input  logic               adc_sdata_i,
  input  logic               bclk_i,
  input  logic               lrclk_i,
  input  logic               dac_sdata_i,
  output int                 dac_errs_o,
  output int                 reg_errs_o,
  output int                 bus_errs_o,
  output int                 frames_o
);

  audio_pkg::coef_t   coef_m[audio_pkg::NUM_TAPS];  // Register mirror
  logic               bypass_m;
  logic               en_m;
  logic [31:0]        frames_m;

  logic               req_we;  // Last request seen on the bus
  audio_pkg::wb_adr_t req_adr;
  audio_pkg::wb_dat_t req_dat;
  audio_pkg::wb_sel_t req_sel;

  logic               bclk_q;
  logic               lrclk_q;
  logic [4:0]         slot;
  logic [31:0]        adc_sr;
  logic [31:0]        dac_sr;
  audio_pkg::sample_t hist_l[$];  // Entry k is delayed by k frames
  audio_pkg::sample_t hist_r[$];
  audio_pkg::stereo_t exp_q[$];   // Filtered pairs on their way to the DAC

  initial begin
    dac_errs_o = 0;
    reg_errs_o = 0;
    bus_errs_o = 0;
    frames_o   = 0;
  end

  function automatic bit is_coef(input audio_pkg::wb_adr_t adr);
    return (int'(adr) >= 4) && (int'(adr) <= 4 * audio_pkg::NUM_TAPS) && (adr[1:0] == 2'b00);
  endfunction

  function automatic audio_pkg::wb_dat_t read_value(input audio_pkg::wb_adr_t adr);
    audio_pkg::coef_t c;
    if (adr == 10'h000) begin
      return {31'b0, bypass_m};
    end else if (is_coef(adr)) begin
      c = coef_m[(int'(adr) - 4) / 4];
      return {{16{c[15]}}, c};
    end else if (adr == 10'h100) begin
      return {31'b0, en_m};
    end else if (adr == 10'h104) begin
      return frames_m;
    end
    return '0;
  endfunction

  // Sum of c[k] * x[n-k], then >>> 15 and clamp to 16 bits
  function automatic audio_pkg::sample_t filter(input bit right);
    longint             acc;
    audio_pkg::sample_t x;
    acc = 0;
    if (bypass_m) begin
      return right ? hist_r[0] : hist_l[0];
    end
    for (int k = 0; k < audio_pkg::NUM_TAPS && k < hist_l.size(); k++) begin
      x   = right ? hist_r[k] : hist_l[k];
      acc = acc + longint'(coef_m[k]) * longint'(x);
    end
    acc = acc >>> 15;
    if (acc > 32767) begin
      return 16'sh7FFF;
    end else if (acc < -32768) begin
      return 16'sh8000;
    end
    return audio_pkg::sample_t'(acc);
  endfunction

  task automatic reset_model();
    foreach (coef_m[k]) coef_m[k] = '0;
    coef_m[0] = 16'sh7FFF;
    bypass_m  = 1'b0;
    en_m      = 1'b0;
    frames_m  = '0;
    bclk_q    = 1'b0;
    lrclk_q   = 1'b0;
    slot      = '0;
    hist_l.delete();
    hist_r.delete();
    exp_q.delete();
    exp_q.push_back('0);  // DAC sends the reset hold value first
    exp_q.push_back('0);
  endtask

  task automatic apply_write();
    if (req_adr == 10'h000 && req_sel[0]) begin
      bypass_m = req_dat[0];
    end
    if (is_coef(req_adr)) begin
      if (req_sel[0]) coef_m[(int'(req_adr) - 4) / 4][7:0] = req_dat[7:0];
      if (req_sel[1]) coef_m[(int'(req_adr) - 4) / 4][15:8] = req_dat[15:8];
    end
    if (req_adr == 10'h100 && req_sel[0]) begin
      en_m = req_dat[0];
    end
    if (req_adr == 10'h104) begin
      frames_m = '0;
    end
  endtask

  task automatic check_response();
    logic unmapped;
    unmapped = (req_adr >= 10'h200);
    if (wb_rsp_i.err && !unmapped) begin
      $display("Error response for mapped address 0x%h", req_adr);
      bus_errs_o++;
    end
    if (wb_rsp_i.ack && unmapped) begin
      $display("Unmapped address 0x%h was acknowledged", req_adr);
      bus_errs_o++;
    end
    if (wb_rsp_i.ack && !unmapped) begin
      if (req_we) begin
        apply_write();
      end else if (wb_rsp_i.dat !== read_value(req_adr)) begin
        $display("[FAIL] wb_rsp_o.dat at 0x%h expected 0x%h actual 0x%h",
                 req_adr, read_value(req_adr), wb_rsp_i.dat);
        reg_errs_o++;
      end
    end
  endtask

  task automatic end_frame();
    audio_pkg::stereo_t expd;
    hist_l.push_front(adc_sr[31:16]);
    hist_r.push_front(adc_sr[15:0]);
    if (hist_l.size() > audio_pkg::NUM_TAPS) begin
      void'(hist_l.pop_back());
      void'(hist_r.pop_back());
    end
    exp_q.push_back({filter(1'b0), filter(1'b1)});
    expd = exp_q.pop_front();  // Pair from two frames back
    if (dac_sr[31:16] !== expd.left) begin
      $display("[FAIL] dac_left expected 0x%h actual 0x%h", expd.left, dac_sr[31:16]);
      dac_errs_o++;
    end
    if (dac_sr[15:0] !== expd.right) begin
      $display("[FAIL] dac_right expected 0x%h actual 0x%h", expd.right, dac_sr[15:0]);
      dac_errs_o++;
    end
    frames_o++;
  endtask

  task automatic take_bit();
    if (lrclk_i !== slot[4]) begin
      $display("lrclk_o is out of step with the bit clock in slot %0d", slot);
      dac_errs_o++;
    end
    adc_sr = {adc_sr[30:0], adc_sdata_i};
    dac_sr = {dac_sr[30:0], dac_sdata_i};
    if (slot == 5'd31) begin
      end_frame();
    end
    slot = slot + 1'b1;
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      reset_model();
    end else begin
      if (wb_rsp_i.ack || wb_rsp_i.err) begin
        check_response();
      end
      if (wb_req_i.cyc && wb_req_i.stb) begin
        req_we  = wb_req_i.we;
        req_adr = wb_req_i.adr;
        req_dat = wb_req_i.dat;
        req_sel = wb_req_i.sel;
      end
      if (lrclk_q && !lrclk_i) begin
        frames_m = frames_m + 1'b1;  // Frame boundary
      end
      if (bclk_i && !bclk_q) begin
        take_bit();
      end
      bclk_q  = bclk_i;
      lrclk_q = lrclk_i;
    end
  end

endmodule

// File: tb/audio_filter_tb.sv
`timescale 1ns/1ns

module audio_filter_tb;

  localparam int WB_TIMEOUT    = 20;
  localparam int FRAME_TIMEOUT = 300;
  localparam int MIN_FRAMES    = 80;  // DAC frames the run must compare

  logic               clk;
  logic               rst_n;
  audio_pkg::wb_req_t wb_req;
  audio_pkg::wb_rsp_t wb_rsp;
  logic               adc_sdata;
  logic               bclk;
  logic               lrclk;
  logic               dac_sdata;

  logic [31:0] adc_q[$];  // Pending ADC frames as {left, right}
  logic [31:0] adc_word;
  logic [4:0]  adc_slot;  // Bit slot the codec is in
  logic        bclk_seen;
  int          tb_errs;
  int          dac_errs;
  int          reg_errs;
  int          bus_errs;
  int          frames_checked;

  audio_filter_top DUT (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .wb_req_i   (wb_req),
    .wb_rsp_o   (wb_rsp),
    .adc_sdata_i(adc_sdata),
    .bclk_o     (bclk),
    .lrclk_o    (lrclk),
    .dac_sdata_o(dac_sdata)
  );

  audio_filter_checker chk (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .wb_req_i   (wb_req),
    .wb_rsp_i   (wb_rsp),
    .adc_sdata_i(adc_sdata),
    .bclk_i     (bclk),
    .lrclk_i    (lrclk),
    .dac_sdata_i(dac_sdata),
    .dac_errs_o (dac_errs),
    .reg_errs_o (reg_errs),
    .bus_errs_o (bus_errs),
    .frames_o   (frames_checked)
  );

  always #5 clk = !clk;

  // ADC side of the codec, next bit after each falling bclk
  always @(posedge clk) begin
    #1;
    if (!rst_n) begin
      adc_slot = '0;
    end else if (bclk_seen && !bclk) begin
      adc_slot = adc_slot + 1'b1;
      if (adc_slot == 5'd0) begin
        adc_word = (adc_q.size() > 0) ? adc_q.pop_front() : '0;  // New frame
      end
    end
    bclk_seen = bclk;
    adc_sdata = adc_word[31 - adc_slot];
  end

  task automatic print_error_counts();
    $display("Errors: dac %0d, register %0d, bus %0d, testbench %0d, frames compared %0d",
             dac_errs, reg_errs, bus_errs, tb_errs, frames_checked);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    print_error_counts();
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic bus_cycle(input logic we, input audio_pkg::wb_adr_t adr,
                           input audio_pkg::wb_dat_t dat);
    bit done;
    done = 1'b0;
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wb_req.sel = 4'hF;
    for (int i = 0; i < WB_TIMEOUT && !done; i++) begin
      @(posedge clk);
      #1;
      done = wb_rsp.ack || wb_rsp.err;
    end
    wb_req.cyc = 1'b0;  // Drop after the response
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    if (!done) begin
      stop_on_timeout("a Wishbone response");
    end
  endtask

  task automatic bus_write(input audio_pkg::wb_adr_t adr, input audio_pkg::wb_dat_t dat);
    bus_cycle(1'b1, adr, dat);
  endtask

  task automatic bus_read(input audio_pkg::wb_adr_t adr);
    bus_cycle(1'b0, adr, '0);  // Checker compares the data
  endtask

  task automatic wait_lrclk(input logic level);
    logic prev;
    bit   seen;
    prev = lrclk;
    seen = 1'b0;
    for (int i = 0; i < FRAME_TIMEOUT && !seen; i++) begin
      @(posedge clk);
      #1;
      seen = (lrclk == level) && (prev != level);
      prev = lrclk;
    end
    if (!seen) begin
      stop_on_timeout(level ? "the right half of a frame" : "a frame boundary");
    end
  endtask

  task automatic wait_frames(input int n);
    repeat (n) wait_lrclk(1'b0);
  endtask

  function automatic logic [15:0] adc_value(input int mode);
    logic [15:0] r;
    r = 16'($urandom);
    case (mode)
      1:       return {4'h7, r[11:0]};  // Near positive full scale
      2:       return {4'h8, r[11:0]};  // Near negative full scale
      default: return r;
    endcase
  endfunction

  task automatic fill_adc(input int n, input int mode);
    repeat (n) adc_q.push_back({adc_value(mode), adc_value(mode)});
  endtask

  task automatic start_codec();
    adc_word = (adc_q.size() > 0) ? adc_q.pop_front() : '0;  // Frame 0 before first bclk
    bus_write(audio_pkg::ADDR_CODEC_CTRL, 32'h1);
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  initial begin
    audio_pkg::coef_t c;
    clk       = 1'b0;
    rst_n     = 1'b0;
    wb_req    = '0;
    adc_sdata = 1'b0;
    adc_word  = '0;
    adc_slot  = '0;
    bclk_seen = 1'b0;
    tb_errs   = 0;
    void'($urandom(32));
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Codec must stay quiet until enabled
    for (int i = 0; i < 200; i++) begin
      @(posedge clk);
      #1;
      if (bclk !== 1'b0 || lrclk !== 1'b0) begin
        $display("[FAIL] bclk_o/lrclk_o expected 0x0/0x0 actual 0x%h/0x%h", bclk, lrclk);
        tb_errs++;
      end
    end
    for (int k = 0; k < audio_pkg::NUM_TAPS; k++) begin
      bus_read(audio_pkg::wb_adr_t'(audio_pkg::ADDR_FIR_COEF0 + 4 * k));
    end
    bus_read(audio_pkg::ADDR_FIR_CTRL);
    bus_read(audio_pkg::ADDR_CODEC_CTRL);
    bus_read(audio_pkg::ADDR_CODEC_FRAMES);
    bus_read(10'h040);  // Hole in the FIR window
    bus_read(10'h200);
    bus_read(10'h3FC);

    // Bypass, DAC repeats the ADC two frames later
    bus_write(audio_pkg::ADDR_FIR_CTRL, 32'h1);
    fill_adc(40, 0);
    start_codec();
    wait_frames(22);

    // Frame counter clear and count
    wait_lrclk(1'b1);
    bus_write(audio_pkg::ADDR_CODEC_FRAMES, '0);
    bus_read(audio_pkg::ADDR_CODEC_FRAMES);
    wait_frames(5);
    wait_lrclk(1'b1);
    bus_read(audio_pkg::ADDR_CODEC_FRAMES);

    // Filtering from an empty delay line
    pulse_reset();
    adc_q.delete();
    for (int k = 0; k < audio_pkg::NUM_TAPS; k++) begin
      c = audio_pkg::coef_t'(int'($urandom_range(0, 8191)) - 4096);
      bus_write(audio_pkg::wb_adr_t'(audio_pkg::ADDR_FIR_COEF0 + 4 * k), {{16{c[15]}}, c});
    end
    fill_adc(40, 0);
    start_codec();
    wait_frames(32);

    // Saturation, coefficients changed in the right half of a frame
    wait_lrclk(1'b1);
    for (int k = 0; k < audio_pkg::NUM_TAPS; k++) begin
      bus_write(audio_pkg::wb_adr_t'(audio_pkg::ADDR_FIR_COEF0 + 4 * k), 32'h0000_7FFF);
    end
    adc_q.delete();
    fill_adc(12, 1);
    fill_adc(12, 2);
    wait_frames(28);

    if (frames_checked < MIN_FRAMES) begin
      $display("Only %0d DAC frames were compared", frames_checked);
      tb_errs++;
    end
    print_error_counts();
    if (tb_errs + dac_errs + reg_errs + bus_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: audio_filter_top.f
hw/audio_pkg.sv
hw/audio_wb_decoder.sv
hw/audio_fir_regs.sv
hw/audio_fir_core.sv
hw/audio_codec_if.sv
hw/audio_filter_top.sv
tb/audio_filter_checker.sv
tb/audio_filter_tb.sv

// File: Bender.yml
package:
  name: audio_filter

sources:
  - hw/audio_pkg.sv
  - hw/audio_wb_decoder.sv
  - hw/audio_fir_regs.sv
  - hw/audio_fir_core.sv
  - hw/audio_codec_if.sv
  - hw/audio_filter_top.sv
  - target: test
    files:
      - tb/audio_filter_checker.sv
      - tb/audio_filter_tb.sv
